//--- hw/beeb_mem_pkg.sv
// memory map package for the beeb glue
// byte, address and slot types
// address field positions and store sizes
// default RAM depth and named ROM image slots

package beeb_mem_pkg;

	// ==================================================
	// address fields
	// ==================================================

	// external bus address, top bit picks RAM
	localparam int ADDR_W = 19;
	// offset inside one 16K block
	localparam int OFFSET_W = 14;
	// slot and block number width
	localparam int SLOT_W = 4;

	// sixteen 16K images in the ROM store
	localparam int ROM_DEPTH = 2 ** (SLOT_W + OFFSET_W);
	// 13 blocks of 16K behind the RAM select
	localparam int RAM_DEPTH_DEF = 212992;

	typedef logic [7:0] byte_t;
	typedef logic [ADDR_W-1:0] mem_addr_t;
	typedef logic [SLOT_W+OFFSET_W-1:0] rom_addr_t;
	typedef logic [SLOT_W-1:0] slot_t;
	typedef logic [SLOT_W-1:0] block_t;

	// ==================================================
	// ROM image slots
	// ==================================================

	// model B images
	localparam slot_t SLOT_B_OS = 4'd0;
	localparam slot_t SLOT_B_MMFS1 = 4'd1;
	localparam slot_t SLOT_B_RAMMASTER = 4'd2;
	localparam slot_t SLOT_B_BASIC = 4'd3;
	localparam slot_t SLOT_B_DFS = 4'd4;
	localparam slot_t SLOT_B_MMFS2 = 4'd14;

	// master images
	localparam slot_t SLOT_M_MMFS1 = 4'd5;
	localparam slot_t SLOT_M_MOS = 4'd6;
	localparam slot_t SLOT_M_DFS = 4'd7;
	localparam slot_t SLOT_M_VIEWSHT = 4'd8;
	localparam slot_t SLOT_M_EDIT = 4'd9;
	localparam slot_t SLOT_M_BASIC = 4'd10;
	localparam slot_t SLOT_M_ADFS = 4'd11;
	localparam slot_t SLOT_M_VIEW = 4'd12;
	localparam slot_t SLOT_M_TERM = 4'd13;
	localparam slot_t SLOT_M_MMFS2 = 4'd15;

endpackage

//--- hw/beeb_input_pkg.sv
// input package for the analog joystick path
// mouse packet field positions
// position, axis and core axis types
// step and position clamp limits, fire bit

package beeb_input_pkg;

	// packet toggles bit 24 on every new report
	typedef logic [24:0] mouse_pkt_t;

	localparam int TOGGLE_BIT = 24;
	// buttons sit in bits 1..0
	localparam int BTN_LO = 0;
	localparam int BTN_W = 2;
	localparam int X_SIGN_BIT = 4;
	localparam int Y_SIGN_BIT = 5;
	// upper seven magnitude bits of each axis
	localparam int X_MAG_LO = 9;
	localparam int Y_MAG_LO = 17;
	localparam int MAG_W = 7;

	typedef logic signed [8:0] pos_t;
	typedef logic [7:0] axis_t;
	typedef logic [11:0] port_axis_t;

	// per-packet step limit and position range
	localparam pos_t STEP_LIMIT = 9'sd10;
	localparam pos_t POS_MIN = -9'sd128;
	localparam pos_t POS_MAX = 9'sd127;

	// fire button inside a 16-bit button word
	localparam int FIRE_BIT = 4;

endpackage

//--- hw/rom_slot_map.sv
// memory pipeline stage 1
// slot table lookup per model and block
// RAM write strobe edge detect
// registered ROM address, RAM address and select tags

module rom_slot_map (
	input  logic                   clk_sys,
	input  logic                   arst_n,
	input  logic                   model_m128,
	input  logic                   fs_v2,
	input  beeb_mem_pkg::mem_addr_t mem_addr,
	input  logic                   mem_we_n,
	input  beeb_mem_pkg::byte_t     mem_din,
	output beeb_mem_pkg::rom_addr_t rom_addr,
	output logic [17:0]            ram_addr,
	output logic                   ram_sel,
	output logic                   rom_valid,
	output logic                   ram_we,
	output beeb_mem_pkg::byte_t     wr_data
);

	beeb_mem_pkg::block_t block;
	beeb_mem_pkg::slot_t  slot;
	logic                 hit;
	logic                 sel_now;
	logic                 we_n_q;

	assign block = mem_addr[beeb_mem_pkg::OFFSET_W +: beeb_mem_pkg::SLOT_W];
	assign sel_now = mem_addr[beeb_mem_pkg::ADDR_W-1];

	// ==================================================
	// slot table
	// ==================================================

	always_comb begin
		slot = beeb_mem_pkg::SLOT_B_OS;
		hit = 1'b0;
		if (!model_m128) begin
			hit = 1'b1;
			case (block)
				4'd3: slot = beeb_mem_pkg::SLOT_B_DFS;
				4'd4: slot = beeb_mem_pkg::SLOT_B_OS;
				4'd8: begin
					// split ROM/RAM slot, never returned to the core
					slot = fs_v2 ? beeb_mem_pkg::SLOT_B_MMFS2 : beeb_mem_pkg::SLOT_B_MMFS1;
					hit = 1'b0;
				end
				4'd14: slot = beeb_mem_pkg::SLOT_B_RAMMASTER;
				4'd15: slot = beeb_mem_pkg::SLOT_B_BASIC;
				default: hit = 1'b0;
			endcase
		end else begin
			hit = 1'b1;
			case (block)
				// filing system version is live, not latched
				4'd3: slot = fs_v2 ? beeb_mem_pkg::SLOT_M_MMFS2 : beeb_mem_pkg::SLOT_M_MMFS1;
				4'd4: slot = beeb_mem_pkg::SLOT_M_MOS;
				4'd9: slot = beeb_mem_pkg::SLOT_M_DFS;
				4'd10: slot = beeb_mem_pkg::SLOT_M_VIEWSHT;
				4'd11: slot = beeb_mem_pkg::SLOT_M_EDIT;
				4'd12: slot = beeb_mem_pkg::SLOT_M_BASIC;
				4'd13: slot = beeb_mem_pkg::SLOT_M_ADFS;
				4'd14: slot = beeb_mem_pkg::SLOT_M_VIEW;
				4'd15: slot = beeb_mem_pkg::SLOT_M_TERM;
				default: hit = 1'b0;
			endcase
		end
	end

	// ==================================================
	// stage register
	// ==================================================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			// strobe idles high
			we_n_q <= 1'b1;
			rom_addr <= '0;
			ram_addr <= '0;
			ram_sel <= 1'b0;
			rom_valid <= 1'b0;
			ram_we <= 1'b0;
			wr_data <= '0;
		end else begin
			we_n_q <= mem_we_n;
			rom_addr <= {slot, mem_addr[beeb_mem_pkg::OFFSET_W-1:0]};
			ram_addr <= mem_addr[17:0];
			ram_sel <= sel_now;
			rom_valid <= hit & ~sel_now;
			// write once, on the falling edge of the strobe
			ram_we <= sel_now & we_n_q & ~mem_we_n;
			wr_data <= mem_din;
		end
	end

endmodule

//--- hw/beeb_mem_array.sv
// memory pipeline stage 2
// ROM image store with shared load and read port
// RAM with a write port and a read port
// registered reads and the read data select

module beeb_mem_array #(
	parameter int RAM_DEPTH = beeb_mem_pkg::RAM_DEPTH_DEF
) (
	input  logic                    clk_sys,
	input  beeb_mem_pkg::rom_addr_t rom_addr,
	input  logic [17:0]             ram_addr,
	input  logic                    ram_sel,
	input  logic                    rom_valid,
	input  logic                    ram_we,
	input  beeb_mem_pkg::byte_t     wr_data,
	input  logic                    core_reset,
	input  logic                    load_wr,
	input  beeb_mem_pkg::rom_addr_t load_addr,
	input  beeb_mem_pkg::byte_t     load_data,
	output beeb_mem_pkg::byte_t     mem_dout
);

	beeb_mem_pkg::byte_t     rom_mem [beeb_mem_pkg::ROM_DEPTH];
	beeb_mem_pkg::byte_t     ram_mem [RAM_DEPTH];
	beeb_mem_pkg::rom_addr_t rom_port;
	logic                    rom_we;
	beeb_mem_pkg::byte_t     rom_q;
	beeb_mem_pkg::byte_t     ram_q;
	logic                    ram_sel_q;
	logic                    rom_valid_q;

	// ==================================================
	// ROM store
	// ==================================================

	// loader owns the port while the core sits in reset
	assign rom_port = core_reset ? load_addr : rom_addr;
	assign rom_we = core_reset & load_wr;

	always_ff @(posedge clk_sys) begin
		if (rom_we) begin
			rom_mem[rom_port] <= load_data;
		end
		rom_q <= rom_mem[rom_port];
	end

	// ==================================================
	// RAM
	// ==================================================

	always_ff @(posedge clk_sys) begin
		// top of the 18-bit range is not populated
		if (ram_we && (ram_addr < 18'(RAM_DEPTH))) begin
			ram_mem[ram_addr] <= wr_data;
		end
		ram_q <= ram_mem[ram_addr];
	end

	// tags follow the data through the read stage
	always_ff @(posedge clk_sys) begin
		ram_sel_q <= ram_sel;
		rom_valid_q <= rom_valid;
	end

	// RAM wins, then a mapped ROM block, else zero
	always_comb begin
		if (ram_sel_q) begin
			mem_dout = ram_q;
		end else if (rom_valid_q) begin
			mem_dout = rom_q;
		end else begin
			mem_dout = '0;
		end
	end

endmodule

//--- hw/mouse_packet_decode.sv
// joystick path stage A
// packet field capture and toggle detect
// step clamp and registered deltas, strobe and button

module mouse_packet_decode (
	input  logic                      clk_sys,
	input  logic                      arst_n,
	input  beeb_input_pkg::mouse_pkt_t mouse_packet,
	output logic                      step_stb,
	output beeb_input_pkg::pos_t       dx,
	output beeb_input_pkg::pos_t       dy,
	output logic                      button
);

	logic                 tog_q;
	logic                 tog_prev;
	beeb_input_pkg::pos_t dx_raw;
	beeb_input_pkg::pos_t dy_raw;
	logic                 btn_raw;

	// limit one packet's movement to the step range
	function automatic beeb_input_pkg::pos_t clamp_step(input beeb_input_pkg::pos_t d);
		beeb_input_pkg::pos_t r;
		r = d;
		if (d > beeb_input_pkg::STEP_LIMIT) begin
			r = beeb_input_pkg::STEP_LIMIT;
		end else if (d < -beeb_input_pkg::STEP_LIMIT) begin
			r = -beeb_input_pkg::STEP_LIMIT;
		end
		return r;
	endfunction

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			tog_q <= 1'b0;
			tog_prev <= 1'b0;
			dx_raw <= '0;
			dy_raw <= '0;
			btn_raw <= 1'b0;
			step_stb <= 1'b0;
			dx <= '0;
			dy <= '0;
			button <= 1'b0;
		end else begin
			// capture fields, sign bit doubled over the upper magnitude
			tog_q <= mouse_packet[beeb_input_pkg::TOGGLE_BIT];
			dx_raw <= {{2{mouse_packet[beeb_input_pkg::X_SIGN_BIT]}},
				mouse_packet[beeb_input_pkg::X_MAG_LO +: beeb_input_pkg::MAG_W]};
			dy_raw <= {{2{mouse_packet[beeb_input_pkg::Y_SIGN_BIT]}},
				mouse_packet[beeb_input_pkg::Y_MAG_LO +: beeb_input_pkg::MAG_W]};
			btn_raw <= |mouse_packet[beeb_input_pkg::BTN_LO +: beeb_input_pkg::BTN_W];
			// new packet when the toggle moved
			tog_prev <= tog_q;
			step_stb <= tog_q ^ tog_prev;
			dx <= clamp_step(dx_raw);
			dy <= clamp_step(dy_raw);
			button <= btn_raw;
		end
	end

endmodule

//--- hw/axis_accumulate.sv
// joystick path stage B
// mouse position accumulators with range clamp
// emulation flag and latched mouse button

module axis_accumulate (
	input  logic                clk_sys,
	input  logic                arst_n,
	input  logic                step_stb,
	input  beeb_input_pkg::pos_t dx,
	input  beeb_input_pkg::pos_t dy,
	input  logic                button,
	input  logic                clear,
	output beeb_input_pkg::pos_t pos_x,
	output beeb_input_pkg::pos_t pos_y,
	output logic                emulating,
	output logic                mouse_fire
);

	logic signed [9:0] sum_x;
	logic signed [9:0] sum_y;

	// hold a position inside the joystick range
	function automatic beeb_input_pkg::pos_t clamp_pos(input logic signed [9:0] v);
		beeb_input_pkg::pos_t r;
		r = beeb_input_pkg::pos_t'(v);
		if (v > beeb_input_pkg::POS_MAX) begin
			r = beeb_input_pkg::POS_MAX;
		end else if (v < beeb_input_pkg::POS_MIN) begin
			r = beeb_input_pkg::POS_MIN;
		end
		return r;
	endfunction

	// y runs the other way on screen
	assign sum_x = pos_x + dx;
	assign sum_y = pos_y - dy;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			pos_x <= '0;
			pos_y <= '0;
			emulating <= 1'b0;
			mouse_fire <= 1'b0;
		end else if (clear) begin
			// real joystick or reset takes over
			pos_x <= '0;
			pos_y <= '0;
			emulating <= 1'b0;
			mouse_fire <= 1'b0;
		end else if (step_stb) begin
			pos_x <= clamp_pos(sum_x);
			pos_y <= clamp_pos(sum_y);
			emulating <= 1'b1;
			mouse_fire <= button;
		end
	end

endmodule

//--- hw/joystick_port_encode.sv
// joystick path stage C
// stick A source select, mouse or joystick 1
// axis inversion and 12-bit widening
// port swap and registered outputs

module joystick_port_encode (
	input  logic                      clk_sys,
	input  logic                      arst_n,
	input  beeb_input_pkg::pos_t       pos_x,
	input  beeb_input_pkg::pos_t       pos_y,
	input  logic                      emulating,
	input  logic                      mouse_fire,
	input  beeb_input_pkg::axis_t      joy1_x,
	input  beeb_input_pkg::axis_t      joy1_y,
	input  beeb_input_pkg::axis_t      joy2_x,
	input  beeb_input_pkg::axis_t      joy2_y,
	input  logic [15:0]               joy1_buttons,
	input  logic [15:0]               joy2_buttons,
	input  logic                      swap_joy,
	output beeb_input_pkg::port_axis_t joystick1_x,
	output beeb_input_pkg::port_axis_t joystick1_y,
	output beeb_input_pkg::port_axis_t joystick2_x,
	output beeb_input_pkg::port_axis_t joystick2_y,
	output logic                      joystick1_fire,
	output logic                      joystick2_fire
);

	beeb_input_pkg::port_axis_t a_x, a_y, b_x, b_y;
	logic                       a_fire;
	logic                       b_fire;

	// 255 minus offset-binary, low nibble repeats the top one
	function automatic beeb_input_pkg::port_axis_t enc_axis(input beeb_input_pkg::axis_t v);
		beeb_input_pkg::axis_t e;
		e = 8'hFF - {~v[7], v[6:0]};
		return {e, e[7:4]};
	endfunction

	// stick A follows the mouse while emulating
	assign a_x = enc_axis(emulating ? beeb_input_pkg::axis_t'(pos_x[7:0]) : joy1_x);
	assign a_y = enc_axis(emulating ? beeb_input_pkg::axis_t'(pos_y[7:0]) : joy1_y);
	assign a_fire = emulating ? mouse_fire : joy1_buttons[beeb_input_pkg::FIRE_BIT];
	assign b_x = enc_axis(joy2_x);
	assign b_y = enc_axis(joy2_y);
	assign b_fire = joy2_buttons[beeb_input_pkg::FIRE_BIT];

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			joystick1_x <= '0;
			joystick1_y <= '0;
			joystick2_x <= '0;
			joystick2_y <= '0;
			joystick1_fire <= 1'b0;
			joystick2_fire <= 1'b0;
		end else begin
			joystick1_x <= swap_joy ? b_x : a_x;
			joystick1_y <= swap_joy ? b_y : a_y;
			joystick2_x <= swap_joy ? a_x : b_x;
			joystick2_y <= swap_joy ? a_y : b_y;
			// core fire inputs are active low
			joystick1_fire <= ~(swap_joy ? b_fire : a_fire);
			joystick2_fire <= ~(swap_joy ? a_fire : b_fire);
		end
	end

endmodule

//--- hw/beeb_glue_top.sv
// top level of the beeb glue
// machine model latch and emulation clear
// memory pipeline, slot map then arrays
// analog joystick pipeline, decode, accumulate, encode

module beeb_glue_top #(
	parameter int RAM_DEPTH = beeb_mem_pkg::RAM_DEPTH_DEF
) (
	input  logic                       clk_sys,
	input  logic                       arst_n,
	input  logic                       core_reset,
	input  logic                       model_m128,
	input  logic                       fs_v2,
	input  logic                       load_wr,
	input  beeb_mem_pkg::rom_addr_t    load_addr,
	input  beeb_mem_pkg::byte_t        load_data,
	input  beeb_mem_pkg::mem_addr_t    mem_addr,
	input  logic                       mem_we_n,
	input  beeb_mem_pkg::byte_t        mem_din,
	input  beeb_input_pkg::mouse_pkt_t mouse_packet,
	input  logic                       mouse_disable,
	input  logic                       swap_joy,
	input  logic [15:0]                joy1_buttons,
	input  logic [15:0]                joy2_buttons,
	input  beeb_input_pkg::axis_t      joy1_x,
	input  beeb_input_pkg::axis_t      joy1_y,
	input  beeb_input_pkg::axis_t      joy2_x,
	input  beeb_input_pkg::axis_t      joy2_y,
	output beeb_mem_pkg::byte_t        mem_dout,
	output beeb_input_pkg::port_axis_t joystick1_x,
	output beeb_input_pkg::port_axis_t joystick1_y,
	output beeb_input_pkg::port_axis_t joystick2_x,
	output beeb_input_pkg::port_axis_t joystick2_y,
	output logic                       joystick1_fire,
	output logic                       joystick2_fire
);

	logic                    m128_q;
	beeb_mem_pkg::rom_addr_t rom_addr;
	logic [17:0]             ram_addr;
	logic                    ram_sel, rom_valid, ram_we;
	beeb_mem_pkg::byte_t     wr_data;
	logic                    step_stb, button, clear;
	beeb_input_pkg::pos_t    dx, dy, pos_x, pos_y;
	logic                    emulating, mouse_fire;

	// ==================================================
	// memory path
	// ==================================================

	// model only changes while the core is held in reset
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			m128_q <= 1'b0;
		end else if (core_reset) begin
			m128_q <= model_m128;
		end
	end

	rom_slot_map u_slot_map (
		.clk_sys(clk_sys), .arst_n(arst_n), .model_m128(m128_q), .fs_v2(fs_v2),
		.mem_addr(mem_addr), .mem_we_n(mem_we_n), .mem_din(mem_din),
		.rom_addr(rom_addr), .ram_addr(ram_addr), .ram_sel(ram_sel),
		.rom_valid(rom_valid), .ram_we(ram_we), .wr_data(wr_data)
	);

	beeb_mem_array #(.RAM_DEPTH(RAM_DEPTH)) u_mem_array (
		.clk_sys(clk_sys), .rom_addr(rom_addr), .ram_addr(ram_addr), .ram_sel(ram_sel),
		.rom_valid(rom_valid), .ram_we(ram_we), .wr_data(wr_data),
		.core_reset(core_reset), .load_wr(load_wr), .load_addr(load_addr),
		.load_data(load_data), .mem_dout(mem_dout)
	);

	// ==================================================
	// analog joystick path
	// ==================================================

	// any joystick button cancels mouse emulation
	assign clear = (|joy1_buttons) | core_reset | mouse_disable;

	mouse_packet_decode u_decode (
		.clk_sys(clk_sys), .arst_n(arst_n), .mouse_packet(mouse_packet),
		.step_stb(step_stb), .dx(dx), .dy(dy), .button(button)
	);

	axis_accumulate u_accumulate (
		.clk_sys(clk_sys), .arst_n(arst_n), .step_stb(step_stb), .dx(dx), .dy(dy),
		.button(button), .clear(clear), .pos_x(pos_x), .pos_y(pos_y),
		.emulating(emulating), .mouse_fire(mouse_fire)
	);

	joystick_port_encode u_encode (
		.clk_sys(clk_sys), .arst_n(arst_n), .pos_x(pos_x), .pos_y(pos_y),
		.emulating(emulating), .mouse_fire(mouse_fire),
		.joy1_x(joy1_x), .joy1_y(joy1_y), .joy2_x(joy2_x), .joy2_y(joy2_y),
		.joy1_buttons(joy1_buttons), .joy2_buttons(joy2_buttons), .swap_joy(swap_joy),
		.joystick1_x(joystick1_x), .joystick1_y(joystick1_y),
		.joystick2_x(joystick2_x), .joystick2_y(joystick2_y),
		.joystick1_fire(joystick1_fire), .joystick2_fire(joystick2_fire)
	);

endmodule

//--- testbench/tb_beeb_checks.svh
// reference models for the beeb glue testbench
// slot table, ROM shadow lookup, clamp and axis encoding
// compare tasks for bytes, core axes and fire bits, error counters

`ifndef TB_BEEB_CHECKS_SVH
`define TB_BEEB_CHECKS_SVH

int check_count = 0;
int error_count = 0;

// shadow of the loaded bytes, two per slot (offset 0 and 0x3FFF)
beeb_mem_pkg::byte_t rom_img [32];

// slot for a block, -1 when the block reads zero
function automatic int ref_slot(input logic m128, input logic fs, input int block);
	int s;
	s = -1;
	if (!m128) begin
		case (block)
			3: s = 4;
			4: s = 0;
			// block 8 has a slot but never returns data
			8: s = -1;
			14: s = 2;
			15: s = 3;
			default: s = -1;
		endcase
	end else begin
		case (block)
			3: s = fs ? 15 : 5;
			4: s = 6;
			9: s = 7;
			10: s = 8;
			11: s = 9;
			12: s = 10;
			13: s = 11;
			14: s = 12;
			15: s = 13;
			default: s = -1;
		endcase
	end
	return s;
endfunction

function automatic beeb_mem_pkg::byte_t ref_rom_byte(input logic m128, input logic fs,
		input beeb_mem_pkg::mem_addr_t addr);
	int s;
	s = ref_slot(m128, fs, int'(addr[17:14]));
	if (s < 0) begin
		return 8'h00;
	end
	return rom_img[s * 2 + ((addr[13:0] == 14'h0) ? 0 : 1)];
endfunction

function automatic int ref_clamp(input int v, input int lo, input int hi);
	if (v < lo) begin
		return lo;
	end
	if (v > hi) begin
		return hi;
	end
	return v;
endfunction

// 255 minus the offset-binary byte, then the top nibble appended
function automatic beeb_input_pkg::port_axis_t ref_axis(input beeb_input_pkg::axis_t v);
	logic [7:0] e;
	e = 8'(127 - int'(v));
	return {e, e[7:4]};
endfunction

task check_byte(input string name, input beeb_mem_pkg::byte_t exp,
		input beeb_mem_pkg::byte_t act);
	check_count++;
	if (act !== exp) begin
		error_count++;
		$display("MISMATCH %s expected %02h actual %02h", name, exp, act);
	end
endtask

task check_axis(input string name, input beeb_input_pkg::port_axis_t exp,
		input beeb_input_pkg::port_axis_t act);
	check_count++;
	if (act !== exp) begin
		error_count++;
		$display("MISMATCH %s expected %03h actual %03h", name, exp, act);
	end
endtask

task check_bit(input string name, input logic exp, input logic act);
	check_count++;
	if (act !== exp) begin
		error_count++;
		$display("MISMATCH %s expected %0b actual %0b", name, exp, act);
	end
endtask

`endif

//--- testbench/tb_beeb_glue.sv
// testbench for the beeb glue top level
// clock, reset and watchdog
// directed tests for ROM map, RAM write edge, mouse and joystick ports

module tb_beeb_glue;

	// ==================================================
	// cycle budget per test, used by the watchdog
	// ==================================================

	localparam int CYC_RESET = 10;
	localparam int CYC_ROM_B = 60;
	localparam int CYC_ROM_M = 90;
	localparam int CYC_ZERO = 80;
	localparam int CYC_RAM = 40;
	localparam int CYC_MOUSE = 260;
	localparam int CYC_JOY = 60;
	localparam int BUDGET_CYC = CYC_RESET + CYC_ROM_B + CYC_ROM_M + CYC_ZERO + CYC_RAM
		+ CYC_MOUSE + CYC_JOY;
	localparam int WATCHDOG_TIME = BUDGET_CYC * 20 + 4000;

	logic                       clk_sys;
	logic                       arst_n;
	logic                       core_reset;
	logic                       model_m128;
	logic                       fs_v2;
	logic                       load_wr;
	beeb_mem_pkg::rom_addr_t    load_addr;
	beeb_mem_pkg::byte_t        load_data;
	beeb_mem_pkg::mem_addr_t    mem_addr;
	logic                       mem_we_n;
	beeb_mem_pkg::byte_t        mem_din;
	beeb_input_pkg::mouse_pkt_t mouse_packet;
	logic                       mouse_disable;
	logic                       swap_joy;
	logic [15:0]                joy1_buttons;
	logic [15:0]                joy2_buttons;
	beeb_input_pkg::axis_t      joy1_x, joy1_y, joy2_x, joy2_y;
	beeb_mem_pkg::byte_t        mem_dout;
	beeb_input_pkg::port_axis_t joystick1_x, joystick1_y, joystick2_x, joystick2_y;
	logic                       joystick1_fire, joystick2_fire;

	// model state kept by the testbench
	logic                       model_latched;
	logic                       tog;
	int                         mx, my;
	logic                       mfire;
	int                         seed_ret;
	beeb_mem_pkg::mem_addr_t    rd_addr_q [$];
	beeb_mem_pkg::byte_t        rd_exp_q [$];

	`include "tb_beeb_checks.svh"

	beeb_glue_top #(.RAM_DEPTH(beeb_mem_pkg::RAM_DEPTH_DEF)) DUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	initial begin
		#(WATCHDOG_TIME);
		$display("timeout: the tests did not finish within the cycle budget");
		$display("sim failed");
		$finish;
	end

	// ==================================================
	// memory helpers
	// ==================================================

	// hold the core in reset, latch the model, optionally load every slot
	task hold_core_reset(input logic m128, input logic do_load);
		@(negedge clk_sys);
		core_reset = 1'b1;
		model_m128 = m128;
		if (do_load) begin
			for (int s = 0; s < 16; s++) begin
				for (int h = 0; h < 2; h++) begin
					@(negedge clk_sys);
					load_wr = 1'b1;
					load_addr = {4'(s), (h != 0) ? 14'h3FFF : 14'h0000};
					load_data = 8'($urandom);
					rom_img[s * 2 + h] = load_data;
				end
			end
		end
		@(negedge clk_sys);
		load_wr = 1'b0;
		core_reset = 1'b0;
		model_latched = m128;
	endtask

	// queue one ROM read at offset 0 or 0x3FFF of a block
	task queue_rom(input int block, input logic hi);
		beeb_mem_pkg::mem_addr_t a;
		a = {1'b0, 4'(block), hi ? 14'h3FFF : 14'h0000};
		rd_addr_q.push_back(a);
		rd_exp_q.push_back(ref_rom_byte(model_latched, fs_v2, a));
	endtask

	// back-to-back reads, each result checked two cycles after its address
	task run_reads(input string name);
		int n;
		n = rd_addr_q.size();
		for (int i = 0; i < n + 2; i++) begin
			@(negedge clk_sys);
			if (i >= 2) begin
				check_byte(name, rd_exp_q[i - 2], mem_dout);
			end
			if (i < n) begin
				mem_addr = rd_addr_q[i];
			end
		end
		rd_addr_q.delete();
		rd_exp_q.delete();
	endtask

	// falling strobe, then new data while the strobe stays low
	task write_ram(input logic [17:0] a, input beeb_mem_pkg::byte_t d_first,
			input beeb_mem_pkg::byte_t d_next);
		@(negedge clk_sys);
		mem_addr = {1'b1, a};
		mem_din = d_first;
		mem_we_n = 1'b0;
		@(negedge clk_sys);
		mem_din = d_next;
		@(negedge clk_sys);
		mem_din = ~d_first;
		@(negedge clk_sys);
		mem_we_n = 1'b1;
	endtask

	// ==================================================
	// joystick helpers
	// ==================================================

	function automatic beeb_input_pkg::mouse_pkt_t make_packet(input logic t, input int dx,
			input int dy, input logic [1:0] btn);
		logic [8:0] ux;
		logic [8:0] uy;
		beeb_input_pkg::mouse_pkt_t p;
		ux = 9'(dx);
		uy = 9'(dy);
		p = '0;
		p[24] = t;
		p[1:0] = btn;
		p[4] = ux[8];
		p[5] = uy[8];
		p[15:9] = ux[6:0];
		p[23:17] = uy[6:0];
		return p;
	endfunction

	// stick A and stick B as plain bytes and active-high fire
	task check_ports(input string name, input beeb_input_pkg::axis_t ax,
			input beeb_input_pkg::axis_t ay, input logic af, input beeb_input_pkg::axis_t bx,
			input beeb_input_pkg::axis_t by, input logic bf);
		if (swap_joy) begin
			check_axis(name, ref_axis(bx), joystick1_x);
			check_axis(name, ref_axis(by), joystick1_y);
			check_bit(name, ~bf, joystick1_fire);
			check_axis(name, ref_axis(ax), joystick2_x);
			check_axis(name, ref_axis(ay), joystick2_y);
			check_bit(name, ~af, joystick2_fire);
		end else begin
			check_axis(name, ref_axis(ax), joystick1_x);
			check_axis(name, ref_axis(ay), joystick1_y);
			check_bit(name, ~af, joystick1_fire);
			check_axis(name, ref_axis(bx), joystick2_x);
			check_axis(name, ref_axis(by), joystick2_y);
			check_bit(name, ~bf, joystick2_fire);
		end
	endtask

	// one packet, model updated, outputs checked four cycles later
	task send_packet(input string name, input int dx, input int dy, input logic [1:0] btn);
		int sdx;
		int sdy;
		@(negedge clk_sys);
		tog = ~tog;
		mouse_packet = make_packet(tog, dx, dy, btn);
		sdx = ref_clamp(dx, -int'(beeb_input_pkg::STEP_LIMIT), int'(beeb_input_pkg::STEP_LIMIT));
		sdy = ref_clamp(dy, -int'(beeb_input_pkg::STEP_LIMIT), int'(beeb_input_pkg::STEP_LIMIT));
		mx = ref_clamp(mx + sdx, int'(beeb_input_pkg::POS_MIN), int'(beeb_input_pkg::POS_MAX));
		my = ref_clamp(my - sdy, int'(beeb_input_pkg::POS_MIN), int'(beeb_input_pkg::POS_MAX));
		mfire = |btn;
		repeat (4) @(negedge clk_sys);
		check_ports(name, 8'(mx), 8'(my), mfire, joy2_x, joy2_y,
			joy2_buttons[beeb_input_pkg::FIRE_BIT]);
	endtask

	// ==================================================
	// directed tests
	// ==================================================

	task test_rom_model_b;
		hold_core_reset(1'b0, 1'b1);
		queue_rom(3, 1'b0);
		queue_rom(3, 1'b1);
		queue_rom(4, 1'b0);
		queue_rom(4, 1'b1);
		queue_rom(14, 1'b0);
		queue_rom(14, 1'b1);
		queue_rom(15, 1'b0);
		queue_rom(15, 1'b1);
		run_reads("test_rom_model_b");
	endtask

	task test_rom_master;
		hold_core_reset(1'b1, 1'b1);
		queue_rom(3, 1'b0);
		queue_rom(4, 1'b1);
		for (int b = 9; b < 16; b++) begin
			queue_rom(b, 1'b0);
			queue_rom(b, 1'b1);
		end
		run_reads("test_rom_master");
		// filing system select follows fs_v2 live
		@(negedge clk_sys);
		fs_v2 = 1'b1;
		queue_rom(3, 1'b0);
		queue_rom(3, 1'b1);
		run_reads("test_rom_master fs_v2 high");
		fs_v2 = 1'b0;
		queue_rom(3, 1'b1);
		run_reads("test_rom_master fs_v2 low");
		// model input ignored while the core runs
		model_m128 = 1'b0;
		queue_rom(4, 1'b0);
		queue_rom(14, 1'b1);
		run_reads("test_rom_master model held");
	endtask

	task test_rom_zero_blocks;
		for (int b = 0; b < 16; b++) begin
			if (ref_slot(model_latched, fs_v2, b) < 0) begin
				queue_rom(b, 1'b0);
			end
		end
		run_reads("test_rom_zero_blocks master");
		hold_core_reset(1'b0, 1'b0);
		for (int b = 0; b < 16; b++) begin
			if (ref_slot(model_latched, fs_v2, b) < 0) begin
				queue_rom(b, 1'b1);
			end
		end
		run_reads("test_rom_zero_blocks model b");
		// block 8 stays zero with either filing system
		fs_v2 = 1'b1;
		queue_rom(8, 1'b0);
		run_reads("test_rom_zero_blocks block 8");
		fs_v2 = 1'b0;
	endtask

	task test_ram_write_edge;
		beeb_mem_pkg::byte_t d0;
		beeb_mem_pkg::byte_t d1;
		d0 = 8'($urandom);
		d1 = 8'($urandom);
		write_ram(18'h00123, d0, ~d0);
		write_ram(18'h33FFF, d1, d1 ^ 8'h5A);
		rd_addr_q.push_back({1'b1, 18'h00123});
		rd_exp_q.push_back(d0);
		rd_addr_q.push_back({1'b1, 18'h33FFF});
		rd_exp_q.push_back(d1);
		run_reads("test_ram_write_edge");
		// strobe on a ROM address must not reach either store
		@(negedge clk_sys);
		mem_addr = {1'b0, 4'd4, 14'h0000};
		mem_din = ~rom_img[0];
		mem_we_n = 1'b0;
		@(negedge clk_sys);
		@(negedge clk_sys);
		mem_we_n = 1'b1;
		queue_rom(4, 1'b0);
		run_reads("test_ram_write_edge rom");
	endtask

	task test_mouse_axes;
		// large positive x, negative y until both clamp high
		for (int i = 0; i < 16; i++) begin
			send_packet("test_mouse_axes up", 40 + i, -(20 + i), 2'(i));
		end
		// full negative steps past the low limit
		for (int i = 0; i < 30; i++) begin
			send_packet("test_mouse_axes down", -64 + (i % 3), 63 - (i % 2), 2'(i >> 1));
		end
		send_packet("test_mouse_axes small", 3, -7, 2'b00);
		send_packet("test_mouse_axes small", -2, 5, 2'b10);
	endtask

	task test_joy_fallback_swap;
		@(negedge clk_sys);
		joy1_x = 8'h20;
		joy1_y = 8'hC5;
		joy2_x = 8'h90;
		joy2_y = 8'h0F;
		joy1_buttons = 16'h0001;
		repeat (2) @(negedge clk_sys);
		check_ports("test_joy_fallback_swap buttons", joy1_x, joy1_y, 1'b0,
			joy2_x, joy2_y, 1'b0);
		// position restarts from zero after the cancel
		joy1_buttons = 16'h0000;
		mx = 0;
		my = 0;
		send_packet("test_joy_fallback_swap restart", 7, -3, 2'b01);
		@(negedge clk_sys);
		mouse_disable = 1'b1;
		repeat (2) @(negedge clk_sys);
		check_ports("test_joy_fallback_swap disable", joy1_x, joy1_y, 1'b0,
			joy2_x, joy2_y, 1'b0);
		mouse_disable = 1'b0;
		mx = 0;
		my = 0;
		send_packet("test_joy_fallback_swap restart", 12, 12, 2'b00);
		// fire on joy1 cancels emulation, swap exchanges the ports
		@(negedge clk_sys);
		joy1_buttons = 16'h0010;
		swap_joy = 1'b1;
		repeat (2) @(negedge clk_sys);
		check_ports("test_joy_fallback_swap swapped", joy1_x, joy1_y, 1'b1,
			joy2_x, joy2_y, 1'b0);
		swap_joy = 1'b0;
		@(negedge clk_sys);
		check_ports("test_joy_fallback_swap straight", joy1_x, joy1_y, 1'b1,
			joy2_x, joy2_y, 1'b0);
	endtask

	// ==================================================
	// main sequence
	// ==================================================

	initial begin
		seed_ret = $urandom(52415);
		arst_n = 1'b0;
		core_reset = 1'b1;
		model_m128 = 1'b0;
		fs_v2 = 1'b0;
		load_wr = 1'b0;
		load_addr = '0;
		load_data = '0;
		mem_addr = '0;
		mem_we_n = 1'b1;
		mem_din = '0;
		mouse_packet = '0;
		mouse_disable = 1'b0;
		swap_joy = 1'b0;
		joy1_buttons = '0;
		joy2_buttons = '0;
		joy1_x = 8'h80;
		joy1_y = 8'h80;
		joy2_x = 8'h80;
		joy2_y = 8'h80;
		model_latched = 1'b0;
		tog = 1'b0;
		mx = 0;
		my = 0;
		mfire = 1'b0;
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		arst_n = 1'b1;
		test_rom_model_b();
		test_rom_master();
		test_rom_zero_blocks();
		test_ram_write_edge();
		test_mouse_axes();
		test_joy_fallback_swap();
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

//--- list.f
+incdir+testbench
hw/beeb_mem_pkg.sv
hw/beeb_input_pkg.sv
hw/rom_slot_map.sv
hw/beeb_mem_array.sv
hw/mouse_packet_decode.sv
hw/axis_accumulate.sv
hw/joystick_port_encode.sv
hw/beeb_glue_top.sv
testbench/tb_beeb_glue.sv

//--- run.sh
#!/bin/sh
# compile the beeb glue testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f list.f --top-module tb_beeb_glue \
	--Mdir obj_dir -o tb_beeb_glue > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_beeb_glue > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "sim passed" sim.log; then
	exit 0
fi
echo "pass line not found in sim.log"
exit 1
